/* hw/gba_video_pkg.sv */
/*
 * Display engine constants
 * Raster geometry, sync positions, frame buffer sizing and the
 * RGB555 pixel type shared by the frame store, the timing
 * generator and the color stage
 */
package gba_video_pkg;

	// ==================================================
	// Picture and frame buffer
	// ==================================================
	localparam int H_VISIBLE = 240;                  // Visible dots per line
	localparam int V_VISIBLE = 160;                  // Visible lines per frame
	localparam int FB_DEPTH  = H_VISIBLE * V_VISIBLE; // 38400 entries
	localparam int FB_AW     = 16;                   // Core-side address width

	// ==================================================
	// Raster timing, all positions in dots and lines
	// ==================================================
	localparam int H_TOTAL  = 399;                   // Dots per line incl. blanking
	localparam int V_START  = 62;                    // First visible line
	localparam int V_END    = V_START + V_VISIBLE;   // First blanked line after picture
	localparam int HS_START = 293;                   // Hsync rises on this dot
	localparam int HS_LEN   = 32;
	localparam int HS_END   = HS_START + HS_LEN;     // Hsync falls on this dot
	localparam int VS_START = 1;                     // Vsync rises on this line
	localparam int VS_END   = 4;                     // Vsync falls on this line

	// Dot clock comes from clk_sys, no separate video clock
	localparam int DOT_DIV      = 8;
	localparam int DIV_W        = $clog2(DOT_DIV);
	localparam int SYNC_STRETCH = 8;                 // Frame-start pulse length in cycles

	// Counter widths, 9 bits each so the line counter can park at 511
	localparam int X_W = 9;
	localparam int Y_W = 9;

	// ==================================================
	// Pixel format
	// ==================================================
	// RGB555, red in the top bits as the core writes it
	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} pixel_t;

endpackage

/* hw/raster_if.sv */
/*
 * Timed pixel stream
 * Carries the dot enable, sync, blanking and pixel color from the
 * raster generator to the color stage
 */
`timescale 1ns/1ps

interface raster_if;

	logic                  ce_pix; // One clk_sys cycle per dot
	logic                  hs;     // Horizontal sync, active high
	logic                  vs;     // Vertical sync, active high
	logic                  hbl;    // Horizontal blank
	logic                  vbl;    // Vertical blank
	gba_video_pkg::pixel_t rgb;    // Pixel for the current dot

	// Timing side drives everything
	modport src (
		output ce_pix, hs, vs, hbl, vbl, rgb
	);

	// Color side only looks
	modport dst (
		input ce_pix, hs, vs, hbl, vbl, rgb
	);

endinterface

/* hw/frame_store.sv */
/*
 * Frame store
 * 240x160 RGB555 frame buffer. Core writes land through a one-cycle
 * strobe port, the raster side reads through a registered port.
 * A write to pixel 0 raises frame_start for a few cycles so the
 * raster can lock onto the core's frame
 */
`timescale 1ns/1ps

module frame_store (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            pix_we,    // Core write strobe
	input  logic [gba_video_pkg::FB_AW-1:0] pix_addr,
	input  gba_video_pkg::pixel_t           pix_data,
	input  logic [gba_video_pkg::FB_AW-1:0] rd_addr,   // From raster_timing
	output gba_video_pkg::pixel_t           rd_data,   // One cycle after rd_addr
	output logic                            frame_start
);

	// ==================================================
	// Pixel RAM
	// ==================================================
	gba_video_pkg::pixel_t mem [gba_video_pkg::FB_DEPTH];

	always_ff @(posedge clk_sys) begin
		if (pix_we)
			mem[pix_addr] <= pix_data; // Core may write every cycle
		rd_data <= mem[rd_addr];       // Registered read, no reset on data
	end

	// ==================================================
	// Frame-start stretcher
	// ==================================================
	logic                                   wr_zero;
	logic [gba_video_pkg::SYNC_STRETCH-1:0] sync_sr;

	// Core starts a new frame by writing the top-left pixel
	assign wr_zero = pix_we && (pix_addr == '0);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sync_sr     <= '0;
			frame_start <= 1'b0;
		end else begin
			// Shift the hit through, pulse stays high while any bit is set
			sync_sr     <= {sync_sr[gba_video_pkg::SYNC_STRETCH-2:0], wr_zero};
			frame_start <= |sync_sr;
		end
	end

	// ==================================================
	// Checks
	// ==================================================
	// Core must stay inside the picture
	a_wr_range: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		pix_we |-> (pix_addr < gba_video_pkg::FB_DEPTH)
	);

endmodule

/* hw/raster_timing.sv */
/*
 * Raster generator
 * Divides clk_sys down to the dot rate, counts 399 dots by 264 lines,
 * places sync and blanking, walks the frame buffer in display order
 * and snaps back to line 0 when the core starts a frame in vblank
 */
`timescale 1ns/1ps

module raster_timing (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            frame_start, // Stretched pixel-0 write
	output logic [gba_video_pkg::FB_AW-1:0] rd_addr,
	input  gba_video_pkg::pixel_t           rd_data,
	raster_if.src                           vid
);

	logic [gba_video_pkg::DIV_W-1:0] div;         // Dot divider
	logic [gba_video_pkg::X_W-1:0]   x;           // Dot within line
	logic [gba_video_pkg::Y_W-1:0]   y;           // Line within frame
	logic [gba_video_pkg::X_W-1:0]   x_cur;
	logic [gba_video_pkg::Y_W-1:0]   y_cur;
	logic                            fs_d;        // frame_start, one cycle late
	logic                            resync_pend; // Resync waiting for the next dot
	logic                            vis_dot;
	logic                            vis_line;

	// ==================================================
	// Dot enable
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div        <= '0;
			vid.ce_pix <= 1'b0;
		end else begin
			if (div == gba_video_pkg::DOT_DIV - 1)
				div <= '0;
			else
				div <= div + 1'b1;
			vid.ce_pix <= (div == gba_video_pkg::DOT_DIV - 1); // One cycle in eight
		end
	end

	// ==================================================
	// Resync request
	// ==================================================
	// Edge can come in any cycle, it is held until the next dot
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			fs_d        <= 1'b0;
			resync_pend <= 1'b0;
		end else begin
			fs_d <= frame_start;
			if (vid.ce_pix)
				resync_pend <= 1'b0; // Consumed by this dot
			if (frame_start && !fs_d && vid.vbl)
				resync_pend <= 1'b1; // Only honoured in vertical blank
		end
	end

	// Dot being processed, a pending resync makes it dot 0 of line 0
	assign x_cur = resync_pend ? '0 : x;
	assign y_cur = resync_pend ? '0 : y;

	assign vis_dot  = (x_cur < gba_video_pkg::H_VISIBLE);
	assign vis_line = (y_cur >= gba_video_pkg::V_START) && (y_cur < gba_video_pkg::V_END);

	// ==================================================
	// Counters, sync, blanking and read address
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			x       <= '0;
			y       <= '0;
			vid.hs  <= 1'b0;
			vid.vs  <= 1'b0;
			vid.hbl <= 1'b0;
			vid.vbl <= 1'b1; // Start in vblank so the first core frame locks us
			rd_addr <= '0;
		end else if (vid.ce_pix) begin
			vid.hbl <= !vis_dot;
			vid.vbl <= !vis_line;

			if (resync_pend) begin
				vid.hs <= 1'b0; // Drop any pulse in flight
				vid.vs <= 1'b0;
			end else begin
				if (x_cur == gba_video_pkg::HS_START) begin
					vid.hs <= 1'b1;
					// Vsync edges line up with the hsync leading edge
					if (y_cur == gba_video_pkg::VS_START)
						vid.vs <= 1'b1;
					if (y_cur == gba_video_pkg::VS_END)
						vid.vs <= 1'b0;
				end
				if (x_cur == gba_video_pkg::HS_END)
					vid.hs <= 1'b0;
			end

			// Address issued now is shown on the next dot
			if (!vis_line)
				rd_addr <= '0;
			else if (vis_dot) begin
				if (rd_addr == gba_video_pkg::FB_DEPTH - 1)
					rd_addr <= '0; // Last pixel, park at 0 for the next frame
				else
					rd_addr <= rd_addr + 1'b1;
			end

			if (x_cur == gba_video_pkg::H_TOTAL - 1) begin
				x <= '0;
				// Free-running raster stops at 511 and stays blanked
				if (&y_cur)
					y <= y_cur;
				else
					y <= y_cur + 1'b1;
			end else begin
				x <= x_cur + 1'b1;
				y <= y_cur;
			end
		end
	end

	// Pixel payload, one per dot
	always_ff @(posedge clk_sys) begin
		if (vid.ce_pix)
			vid.rgb <= rd_data;
	end

	// ==================================================
	// Checks
	// ==================================================
	a_ce_single: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		vid.ce_pix |=> !vid.ce_pix
	);

	// Frame store only has FB_DEPTH entries
	a_rd_range: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		rd_addr < gba_video_pkg::FB_DEPTH
	);

endmodule

/* hw/color_grade.sv */
/*
 * Color stage
 * Widens RGB555 to 8 bits per channel, optionally pulls the picture
 * toward gray through a luma mix, and registers the VGA outputs
 */
`timescale 1ns/1ps

module color_grade (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       desat,    // 1 = washed-out handheld look
	raster_if.dst      vid,
	output logic       ce_pixel,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs,
	output logic       vga_de
);

	logic [7:0] r_in;
	logic [7:0] g_in;
	logic [7:0] b_in;
	logic [7:0] luma;

	// ==================================================
	// Channel math
	// ==================================================
	// 5 to 8 bits, top bits repeated so full scale stays full scale
	function automatic logic [7:0] widen(input logic [4:0] c);
		return {c, c[4:2]};
	endfunction

	// Three quarters of the channel plus a quarter of luma, wraps on overflow
	function automatic logic [7:0] mix(input logic [7:0] c, input logic [7:0] l);
		return (c >> 1) + (c >> 2) + (l >> 2);
	endfunction

	assign r_in = widen(vid.rgb.r);
	assign g_in = widen(vid.rgb.g);
	assign b_in = widen(vid.rgb.b);

	// Rough luma weights 1/4 R, 5/8 G, 1/8 B
	assign luma = (r_in >> 2) + (g_in >> 1) + (g_in >> 3) + (b_in >> 3);

	// ==================================================
	// Output registers
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ce_pixel <= 1'b0;
			vga_hs   <= 1'b0;
			vga_vs   <= 1'b0;
			vga_de   <= 1'b0;
		end else begin
			ce_pixel <= vid.ce_pix; // Lines up with the new output values
			if (vid.ce_pix) begin
				vga_hs <= vid.hs;
				vga_vs <= vid.vs;
				vga_de <= !(vid.hbl || vid.vbl);
			end
		end
	end

	// Color payload
	always_ff @(posedge clk_sys) begin
		if (vid.ce_pix) begin
			vga_r <= desat ? mix(r_in, luma) : r_in;
			vga_g <= desat ? mix(g_in, luma) : g_in;
			vga_b <= desat ? mix(b_in, luma) : b_in;
		end
	end

	// Sync pulses sit in the blanking, never over picture
	a_de_no_sync: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		vga_de |-> (!vga_hs && !vga_vs)
	);

endmodule

/* hw/gba_video_top.sv */
/*
 * Display engine top
 * Core pixel writes go into the frame store, the raster generator
 * scans it out with GBA timing and the color stage drives VGA
 */
`timescale 1ns/1ps

module gba_video_top (
	input  logic                            clk_sys,
	input  logic                            rst_n,

	// Core write port
	input  logic                            pix_we,
	input  logic [gba_video_pkg::FB_AW-1:0] pix_addr,
	input  gba_video_pkg::pixel_t           pix_data,

	input  logic                            desat,   // Luma mix on/off

	// Video out
	output logic                            ce_pixel,
	output logic [7:0]                      vga_r,
	output logic [7:0]                      vga_g,
	output logic [7:0]                      vga_b,
	output logic                            vga_hs,
	output logic                            vga_vs,
	output logic                            vga_de
);

	logic                            frame_start;
	logic [gba_video_pkg::FB_AW-1:0] rd_addr;
	gba_video_pkg::pixel_t           rd_data;

	raster_if vid ();

	// ==================================================
	// Input side
	// ==================================================
	frame_store u_store (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.pix_we      (pix_we),
		.pix_addr    (pix_addr),
		.pix_data    (pix_data),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.frame_start (frame_start)
	);

	raster_timing u_timing (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.vid         (vid.src)
	);

	// Output side
	color_grade u_grade (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.desat    (desat),
		.vid      (vid.dst),
		.ce_pixel (ce_pixel),
		.vga_r    (vga_r),
		.vga_g    (vga_g),
		.vga_b    (vga_b),
		.vga_hs   (vga_hs),
		.vga_vs   (vga_vs),
		.vga_de   (vga_de)
	);

endmodule

/* sim/tb_video_checker.sv */
/*
 * Video checker
 * Mirrors every core write into a shadow frame, then follows the VGA
 * side dot by dot: pixel colors, line and frame sizes, sync widths
 */
`timescale 1ns/1ps

module tb_video_checker (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            pix_we,
	input  logic [gba_video_pkg::FB_AW-1:0] pix_addr,
	input  gba_video_pkg::pixel_t           pix_data,
	input  logic                            desat,
	input  logic                            ce_pixel,
	input  logic [7:0]                      vga_r,
	input  logic [7:0]                      vga_g,
	input  logic [7:0]                      vga_b,
	input  logic                            vga_hs,
	input  logic                            vga_vs,
	input  logic                            vga_de,
	output int                              frames_done,
	output int                              pix_errors,
	output int                              timing_errors
);

	gba_video_pkg::pixel_t shadow [gba_video_pkg::FB_DEPTH]; // What the RAM should hold

	int   dot_cnt;       // Dots since reset
	int   gap;           // clk_sys cycles since last dot
	int   since_rst;
	int   pix_n;         // Active pixel index in frame
	int   run;           // Active dots in current line
	int   lines;
	int   hs_start;
	int   vs_start;
	int   vs_fall;
	logic hs_chk;
	logic in_pic;        // Between first and last vga_de of a frame
	logic prev_hs;
	logic prev_vs;
	logic prev_de;
	logic seen_ce;

	// ==================================================
	// Reference color rules
	// ==================================================
	function automatic logic [7:0] expand5(input logic [4:0] c);
		expand5 = (8'(c) << 3) | 8'(c >> 2); // Top 3 bits refill the low end
	endfunction

	function automatic logic [23:0] expected_rgb(input gba_video_pkg::pixel_t p, input logic ds);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic [7:0] y;
		r = expand5(p[14:10]);
		g = expand5(p[9:5]);
		b = expand5(p[4:0]);
		y = 8'((r >> 2) + (g >> 1) + (g >> 3) + (b >> 3));
		if (ds) begin
			r = 8'((r >> 1) + (r >> 2) + (y >> 2));
			g = 8'((g >> 1) + (g >> 2) + (y >> 2));
			b = 8'((b >> 1) + (b >> 2) + (y >> 2));
		end
		expected_rgb = {r, g, b};
	endfunction

	// Same edge as the DUT RAM
	always @(posedge clk_sys) begin
		if (pix_we)
			shadow[pix_addr] <= pix_data;
	end

	// ==================================================
	// Dot monitor, sampled mid-cycle
	// ==================================================
	always @(negedge clk_sys) begin
		if (!rst_n) begin
			{frames_done, pix_errors, timing_errors} = '0;
			{dot_cnt, gap, since_rst, pix_n, run, lines} = '0;
			{hs_start, vs_start, vs_fall} = '0;
			{hs_chk, in_pic, prev_hs, prev_vs, prev_de, seen_ce} = '0;
		end else begin
			since_rst++;
			gap++;
			if (since_rst < 64 && (vga_hs || vga_vs || vga_de)) begin
				timing_errors++;
				$display("Sync or enable output went high right after reset at %0t", $time);
			end
			if (ce_pixel) begin
				if (seen_ce && gap != gba_video_pkg::DOT_DIV) begin
					timing_errors++;
					$display("mismatch at %0t: ce_pixel gap %0d", $time, gap);
				end
				seen_ce = 1'b1;
				gap     = 0;
				dot_cnt++;

				// Hsync is only measured inside the picture, resync can cut it elsewhere
				if (vga_hs && !prev_hs) begin
					hs_start = dot_cnt;
					hs_chk   = in_pic;
				end
				if (!vga_hs && prev_hs && hs_chk && dot_cnt - hs_start != gba_video_pkg::HS_LEN) begin
					timing_errors++;
					$display("mismatch at %0t: hsync %0d dots", $time, dot_cnt - hs_start);
				end
				if (vga_vs && !prev_vs)
					vs_start = dot_cnt;
				if (!vga_vs && prev_vs) begin
					vs_fall = dot_cnt;
					if (dot_cnt - vs_start != 3 * gba_video_pkg::H_TOTAL) begin
						timing_errors++;
						$display("mismatch at %0t: vsync %0d dots", $time, dot_cnt - vs_start);
					end
				end

				if (vga_de) begin
					if (!prev_de) begin
						run = 0;
						// First line of a frame, distance back to the vsync falling edge
						if (!in_pic && dot_cnt - vs_fall != (gba_video_pkg::V_START
								- gba_video_pkg::VS_END) * gba_video_pkg::H_TOTAL
								- gba_video_pkg::HS_START) begin
							timing_errors++;
							$display("mismatch at %0t: vsync to picture %0d dots", $time,
								dot_cnt - vs_fall);
						end
						in_pic = 1'b1;
					end
					if (pix_n >= gba_video_pkg::FB_DEPTH) begin
						timing_errors++;
						$display("mismatch at %0t: pixel %0d beyond frame", $time, pix_n);
					end else if ({vga_r, vga_g, vga_b} != expected_rgb(shadow[pix_n], desat)) begin
						pix_errors++;
						$display("mismatch at %0t: pixel %0d got %06h exp %06h", $time, pix_n,
							{vga_r, vga_g, vga_b}, expected_rgb(shadow[pix_n], desat));
					end
					pix_n++;
					run++;
				end else if (prev_de) begin
					lines++;
					if (run != gba_video_pkg::H_VISIBLE) begin
						timing_errors++;
						$display("mismatch at %0t: line of %0d dots", $time, run);
					end
					if (pix_n >= gba_video_pkg::FB_DEPTH) begin
						if (lines != gba_video_pkg::V_VISIBLE) begin
							timing_errors++;
							$display("mismatch at %0t: frame of %0d lines", $time, lines);
						end
						frames_done++;
						{pix_n, lines} = '0;
						in_pic         = 1'b0;
					end
				end
				prev_hs = vga_hs;
				prev_vs = vga_vs;
				prev_de = vga_de;
			end
		end
	end

endmodule

/* sim/tb_gba_video.sv */
/*
 * Display engine testbench
 * Fills the frame buffer from a stimulus table, keeps the raster
 * locked with a pixel-0 write per frame and lets the checker judge
 */
`timescale 1ns/1ps

module tb_gba_video;

	typedef struct packed {
		logic       rnd;     // 1 = random contents, 0 = address pattern
		logic       desat;
		logic [7:0] frames;  // Frames to observe
	} entry_t;

	localparam int N_ENTRY   = 3;
	localparam int FRAME_CYC = gba_video_pkg::H_TOTAL * 264 * gba_video_pkg::DOT_DIV;

	entry_t stim [N_ENTRY] = '{
		'{1'b0, 1'b0, 8'd2},  // Pattern, plain widening, rewrite between frames
		'{1'b1, 1'b1, 8'd1},  // Random, luma mix
		'{1'b1, 1'b0, 8'd1}
	};

	logic                            clk_sys;
	logic                            rst_n;
	logic                            pix_we;
	logic [gba_video_pkg::FB_AW-1:0] pix_addr;
	gba_video_pkg::pixel_t           pix_data;
	logic                            desat;
	logic                            ce_pixel;
	logic [7:0]                      vga_r;
	logic [7:0]                      vga_g;
	logic [7:0]                      vga_b;
	logic                            vga_hs;
	logic                            vga_vs;
	logic                            vga_de;
	int                              frames_done;
	int                              pix_errors;
	int                              timing_errors;
	integer                          seed = 32'h97219d42;
	longint                          cycles;
	longint                          limit;
	int                              total;
	int                              frames_seen;

	gba_video_top uut (.*);

	tb_video_checker u_checker (.*);

	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	// ==================================================
	// Run limit
	// ==================================================
	always @(posedge clk_sys) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout after %0d cycles, frames seen %0d of %0d", cycles, frames_seen, total);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic gba_video_pkg::pixel_t addr_pattern(input logic [31:0] a);
		addr_pattern = 15'((a * 32'h2f1) ^ (a >> 3)); // Every address bit reaches the data
	endfunction

	task automatic write_pixel(input int addr, input gba_video_pkg::pixel_t data);
		@(posedge clk_sys);
		#1;
		pix_we   = 1'b1;
		pix_addr = addr[gba_video_pkg::FB_AW-1:0];
		pix_data = data;
	endtask

	// Whole frame, pixel 0 last so the raster restarts on it
	task automatic fill_frame(input logic rnd);
		for (int a = 1; a <= gba_video_pkg::FB_DEPTH; a++)
			write_pixel(a % gba_video_pkg::FB_DEPTH,
				rnd ? 15'($random(seed)) : addr_pattern(a % gba_video_pkg::FB_DEPTH));
		@(posedge clk_sys);
		#1 pix_we = 1'b0;
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		cycles      = 0;
		total       = 0;
		frames_seen = 0;
		for (int i = 0; i < N_ENTRY; i++)
			total += stim[i].frames;
		limit    = longint'(total + 2) * FRAME_CYC;
		rst_n    = 1'b0;
		pix_we   = 1'b0;
		pix_addr = '0;
		pix_data = '0;
		desat    = 1'b0;
		repeat (8) @(posedge clk_sys);
		#1 rst_n = 1'b1;

		for (int i = 0; i < N_ENTRY; i++) begin
			@(posedge clk_sys);
			#1 desat = stim[i].desat;     // Still in vblank here
			fill_frame(stim[i].rnd);
			for (int f = 0; f < stim[i].frames; f++) begin
				wait (frames_done > frames_seen);
				frames_seen++;
				if (f < stim[i].frames - 1) begin
					// Second hsync after the picture ends inside vertical blank
					repeat (2) @(negedge vga_hs);
					// Change one pixel, then restart the raster
					write_pixel((f * 977 + 1234) % gba_video_pkg::FB_DEPTH, 15'($random(seed)));
					write_pixel(0, 15'($random(seed)));
					@(posedge clk_sys);
					#1 pix_we = 1'b0;
				end
			end
		end

		@(posedge clk_sys);
		$display("Frames %0d, pixel errors %0d, timing errors %0d",
			frames_seen, pix_errors, timing_errors);
		if (pix_errors == 0 && timing_errors == 0 && frames_seen == total)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* Bender.yml */
package:
  name: gba_video
  authors: []

sources:
  - hw/gba_video_pkg.sv
  - hw/raster_if.sv
  - hw/frame_store.sv
  - hw/raster_timing.sv
  - hw/color_grade.sv
  - hw/gba_video_top.sv

  - target: test
    files:
      - sim/tb_video_checker.sv
      - sim/tb_gba_video.sv

/* list.f */
hw/gba_video_pkg.sv
hw/raster_if.sv
hw/frame_store.sv
hw/raster_timing.sv
hw/color_grade.sv
hw/gba_video_top.sv
sim/tb_video_checker.sv
sim/tb_gba_video.sv
